// ==== hw/emu_pkg.sv ====
package emu_pkg;

    // Host register port widths
    localparam int CSR_ADDR_W = 12;
    localparam int CSR_DATA_W = 32;
    localparam int CSR_STRB_W = CSR_DATA_W / 8;

    // Emulated design side
    localparam int CYCLE_W = 64;
    localparam int TRIG_W  = 32;

    typedef logic [CSR_ADDR_W-1:0] csr_addr_t;
    typedef logic [CSR_DATA_W-1:0] csr_data_t;
    typedef logic [CSR_STRB_W-1:0] csr_strb_t;
    typedef logic [CYCLE_W-1:0]    cycle_t;
    typedef logic [TRIG_W-1:0]     trig_t;
    typedef logic [1:0]            axi_resp_t;

    localparam axi_resp_t RESP_OKAY   = 2'b00;
    localparam axi_resp_t RESP_SLVERR = 2'b10;

    // Register map, byte offsets
    localparam csr_addr_t ADDR_EMU_STAT  = 12'h000;
    localparam csr_addr_t ADDR_TRIG_STAT = 12'h004;
    localparam csr_addr_t ADDR_CYCLE_LO  = 12'h008;
    localparam csr_addr_t ADDR_CYCLE_HI  = 12'h00C;
    localparam csr_addr_t ADDR_STEP      = 12'h010;

    // EMU_STAT fields
    // Bit 31 is read only and tells whether the step count caused the last halt
    localparam int STAT_HALT_BIT      = 0;
    localparam int STAT_RESET_BIT     = 1;
    localparam int STAT_STEP_TRIG_BIT = 31;

    // One accepted register write with a full strobe
    // valid is high for a single cycle
    typedef struct packed {
        csr_addr_t addr;
        csr_data_t data;
        logic      valid;
    } csr_wr_t;

    // Everything the read path can return
    typedef struct packed {
        csr_data_t stat;
        trig_t     trig;
        cycle_t    cycle;
        csr_data_t step;
    } csr_view_t;

endpackage

// ==== hw/axil_csr_write.sv ====
`timescale 1ns/1ps

module axil_csr_write import emu_pkg::*; (
    input  logic      clk,
    input  logic      rst,

    input  logic      awvalid,
    output logic      awready,
    input  csr_addr_t awaddr,

    input  logic      wvalid,
    output logic      wready,
    input  csr_data_t wdata,
    input  csr_strb_t wstrb,

    output logic      bvalid,
    input  logic      bready,
    output axi_resp_t bresp,

    output csr_wr_t   csr_wr
);

    csr_addr_t addr_q;
    csr_data_t data_q;
    logic      addr_held;
    logic      data_held;
    logic      strb_err;
    logic      resp_pend;
    logic      both_held;

    assign both_held = addr_held && data_held;

    // Address and data may arrive in either order; the pair is
    // consumed on the cycle both slots are full
    always_ff @(posedge clk) begin
        if (rst) begin
            addr_held <= 1'b0;
            data_held <= 1'b0;
            strb_err  <= 1'b0;
            resp_pend <= 1'b0;
        end else begin
            if (awvalid && awready) begin
                addr_held <= 1'b1;
            end
            if (wvalid && wready) begin
                data_held <= 1'b1;
                strb_err  <= (wstrb != '1);
            end
            if (both_held) begin
                addr_held <= 1'b0;
                data_held <= 1'b0;
                resp_pend <= 1'b1;
            end
            if (bvalid && bready) begin
                resp_pend <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (awvalid && awready) begin
            addr_q <= awaddr;
        end
        if (wvalid && wready) begin
            data_q <= wdata;
        end
    end

    // No new address until the previous response is taken
    assign awready = !addr_held && !resp_pend;
    assign wready  = !data_held;
    assign bvalid  = resp_pend;
    assign bresp   = strb_err ? RESP_SLVERR : RESP_OKAY;

    // Partial strobes are answered but never reach the registers
    always_comb begin
        csr_wr.addr  = addr_q;
        csr_wr.data  = data_q;
        csr_wr.valid = both_held && !strb_err;
    end

endmodule

// ==== hw/axil_csr_read.sv ====
`timescale 1ns/1ps

module axil_csr_read import emu_pkg::*; (
    input  logic      clk,
    input  logic      rst,

    input  logic      arvalid,
    output logic      arready,
    input  csr_addr_t araddr,

    output logic      rvalid,
    input  logic      rready,
    output csr_data_t rdata,
    output axi_resp_t rresp,

    input  csr_view_t view
);

    csr_addr_t addr_q;
    logic      addr_held;
    logic      capture;
    csr_data_t sel_word;

    // Sample once per held address, then wait for the master
    assign capture = addr_held && !rvalid;

    always_comb begin
        case (addr_q)
            ADDR_EMU_STAT: begin
                sel_word = view.stat;
            end
            ADDR_TRIG_STAT: begin
                sel_word = view.trig;
            end
            ADDR_CYCLE_LO: begin
                sel_word = view.cycle[CSR_DATA_W-1:0];
            end
            ADDR_CYCLE_HI: begin
                sel_word = view.cycle[CYCLE_W-1:CSR_DATA_W];
            end
            ADDR_STEP: begin
                sel_word = view.step;
            end
            default: begin
                // Unmapped offsets read as zero
                sel_word = '0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            addr_held <= 1'b0;
            rvalid    <= 1'b0;
        end else begin
            if (arvalid && arready) begin
                addr_held <= 1'b1;
            end
            if (capture) begin
                rvalid <= 1'b1;
            end
            if (rvalid && rready) begin
                addr_held <= 1'b0;
                rvalid    <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (arvalid && arready) begin
            addr_q <= araddr;
        end
        if (capture) begin
            rdata <= sel_word;
        end
    end

    // The address slot stays busy until R is taken
    assign arready = !addr_held;
    assign rresp   = RESP_OKAY;

endmodule

// ==== hw/emu_run_ctrl.sv ====
`timescale 1ns/1ps

module emu_run_ctrl import emu_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  csr_wr_t   csr_wr,
    input  logic      step_fire,
    input  trig_t     dut_trig,
    output logic      halt,
    output logic      dut_reset,
    output csr_data_t stat_word,
    output trig_t     trig_stat
);

    logic trigger;
    logic stat_wr;
    logic step_trig;

    // Any design trigger line or the end of a step run stops the design
    assign trigger = step_fire || (dut_trig != '0);
    assign stat_wr = csr_wr.valid && (csr_wr.addr == ADDR_EMU_STAT);

    // A trigger overrides a host write landing in the same cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            halt      <= 1'b1;
            dut_reset <= 1'b1;
            step_trig <= 1'b0;
        end else if (trigger) begin
            halt      <= 1'b1;
            step_trig <= step_fire;
        end else if (stat_wr) begin
            halt      <= csr_wr.data[STAT_HALT_BIT];
            dut_reset <= csr_wr.data[STAT_RESET_BIT];
        end
    end

    // Lines that fired on the last trigger, kept until the next one
    always_ff @(posedge clk) begin
        if (rst) begin
            trig_stat <= '0;
        end else if (trigger) begin
            trig_stat <= dut_trig;
        end
    end

    always_comb begin
        stat_word                     = '0;
        stat_word[STAT_HALT_BIT]      = halt;
        stat_word[STAT_RESET_BIT]     = dut_reset;
        stat_word[STAT_STEP_TRIG_BIT] = step_trig;
    end

endmodule

// ==== hw/step_counter.sv ====
`timescale 1ns/1ps

module step_counter import emu_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  csr_wr_t   csr_wr,
    input  logic      halt,
    output csr_data_t step_count,
    output logic      step_fire
);

    logic step_wr;

    assign step_wr = csr_wr.valid && (csr_wr.addr == ADDR_STEP);

    // Last step: the count is about to reach zero while running.
    // A STEP write in that cycle reloads instead, so no fire
    assign step_fire = !halt && !step_wr && (step_count == csr_data_t'(1));

    always_ff @(posedge clk) begin
        if (rst) begin
            step_count <= '0;
        end else if (step_wr) begin
            step_count <= csr_wr.data;
        end else if (!halt && (step_count != '0)) begin
            step_count <= step_count - csr_data_t'(1);
        end
    end

endmodule

// ==== hw/cycle_counter.sv ====
`timescale 1ns/1ps

module cycle_counter import emu_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  csr_wr_t csr_wr,
    input  logic    halt,
    output cycle_t  cycle_count
);

    logic lo_wr;
    logic hi_wr;

    assign lo_wr = csr_wr.valid && (csr_wr.addr == ADDR_CYCLE_LO);
    assign hi_wr = csr_wr.valid && (csr_wr.addr == ADDR_CYCLE_HI);

    // Counts design cycles; host loads only land while halted
    always_ff @(posedge clk) begin
        if (rst) begin
            cycle_count <= '0;
        end else if (!halt) begin
            cycle_count <= cycle_count + cycle_t'(1);
        end else begin
            if (lo_wr) begin
                cycle_count[CSR_DATA_W-1:0] <= csr_wr.data;
            end
            if (hi_wr) begin
                cycle_count[CYCLE_W-1:CSR_DATA_W] <= csr_wr.data;
            end
        end
    end

endmodule

// ==== hw/emu_ctrl_top.sv ====
`timescale 1ns/1ps

module emu_ctrl_top import emu_pkg::*; (
    input  logic      clk,
    input  logic      rst,

    // AXI4-Lite slave
    input  logic      s_axil_awvalid,
    output logic      s_axil_awready,
    input  csr_addr_t s_axil_awaddr,
    input  logic      s_axil_wvalid,
    output logic      s_axil_wready,
    input  csr_data_t s_axil_wdata,
    input  csr_strb_t s_axil_wstrb,
    output logic      s_axil_bvalid,
    input  logic      s_axil_bready,
    output axi_resp_t s_axil_bresp,
    input  logic      s_axil_arvalid,
    output logic      s_axil_arready,
    input  csr_addr_t s_axil_araddr,
    output logic      s_axil_rvalid,
    input  logic      s_axil_rready,
    output csr_data_t s_axil_rdata,
    output axi_resp_t s_axil_rresp,

    // Emulated design
    input  trig_t     dut_trig,
    output logic      dut_halt,
    output logic      dut_reset
);

    csr_wr_t   csr_wr;
    csr_view_t csr_view;
    logic      step_fire;
    csr_data_t stat_word;
    csr_data_t step_count;
    trig_t     trig_stat;
    cycle_t    cycle_count;

    assign csr_view = '{
        stat:  stat_word,
        trig:  trig_stat,
        cycle: cycle_count,
        step:  step_count
    };

    axil_csr_write axil_csr_write_inst (
        .clk     (clk),
        .rst     (rst),
        .awvalid (s_axil_awvalid),
        .awready (s_axil_awready),
        .awaddr  (s_axil_awaddr),
        .wvalid  (s_axil_wvalid),
        .wready  (s_axil_wready),
        .wdata   (s_axil_wdata),
        .wstrb   (s_axil_wstrb),
        .bvalid  (s_axil_bvalid),
        .bready  (s_axil_bready),
        .bresp   (s_axil_bresp),
        .csr_wr  (csr_wr)
    );

    axil_csr_read axil_csr_read_inst (
        .clk     (clk),
        .rst     (rst),
        .arvalid (s_axil_arvalid),
        .arready (s_axil_arready),
        .araddr  (s_axil_araddr),
        .rvalid  (s_axil_rvalid),
        .rready  (s_axil_rready),
        .rdata   (s_axil_rdata),
        .rresp   (s_axil_rresp),
        .view    (csr_view)
    );

    emu_run_ctrl emu_run_ctrl_inst (
        .clk       (clk),
        .rst       (rst),
        .csr_wr    (csr_wr),
        .step_fire (step_fire),
        .dut_trig  (dut_trig),
        .halt      (dut_halt),
        .dut_reset (dut_reset),
        .stat_word (stat_word),
        .trig_stat (trig_stat)
    );

    step_counter step_counter_inst (
        .clk        (clk),
        .rst        (rst),
        .csr_wr     (csr_wr),
        .halt       (dut_halt),
        .step_count (step_count),
        .step_fire  (step_fire)
    );

    cycle_counter cycle_counter_inst (
        .clk         (clk),
        .rst         (rst),
        .csr_wr      (csr_wr),
        .halt        (dut_halt),
        .cycle_count (cycle_count)
    );

endmodule

// ==== tests/tb_emu_ctrl.sv ====
`timescale 1ns/1ps

module tb_emu_ctrl import emu_pkg::*; ();

    // Roughly ten times the length of all directed tests
    localparam int TIMEOUT_CYCLES = 5000;

    logic      clk;
    logic      rst;
    logic      awvalid;
    logic      awready;
    csr_addr_t awaddr;
    logic      wvalid;
    logic      wready;
    csr_data_t wdata;
    csr_strb_t wstrb;
    logic      bvalid;
    logic      bready;
    axi_resp_t bresp;
    logic      arvalid;
    logic      arready;
    csr_addr_t araddr;
    logic      rvalid;
    logic      rready;
    csr_data_t rdata;
    axi_resp_t rresp;
    trig_t     dut_trig;
    logic      dut_halt;
    logic      dut_reset;

    int errors;
    int sim_cycles;
    int low_cycles;

    emu_ctrl_top emu_ctrl_top_inst (
        .clk            (clk),
        .rst            (rst),
        .s_axil_awvalid (awvalid),
        .s_axil_awready (awready),
        .s_axil_awaddr  (awaddr),
        .s_axil_wvalid  (wvalid),
        .s_axil_wready  (wready),
        .s_axil_wdata   (wdata),
        .s_axil_wstrb   (wstrb),
        .s_axil_bvalid  (bvalid),
        .s_axil_bready  (bready),
        .s_axil_bresp   (bresp),
        .s_axil_arvalid (arvalid),
        .s_axil_arready (arready),
        .s_axil_araddr  (araddr),
        .s_axil_rvalid  (rvalid),
        .s_axil_rready  (rready),
        .s_axil_rdata   (rdata),
        .s_axil_rresp   (rresp),
        .dut_trig       (dut_trig),
        .dut_halt       (dut_halt),
        .dut_reset      (dut_reset)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Cycles the emulated design spends running, sampled mid-cycle
    always @(negedge clk) begin
        if (!dut_halt) begin
            low_cycles++;
        end
    end

    task automatic check_data(input string name, input csr_data_t exp, input csr_data_t act);
        if (act !== exp) begin
            $display("Error %s: expected 0x%08h, actual 0x%08h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_resp(input string name, input axi_resp_t exp, input axi_resp_t act);
        if (act !== exp) begin
            $display("Error %s: expected resp %0d, actual resp %0d", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("Error %s: expected %0b, actual %0b", name, exp, act);
            errors++;
        end
    endtask

    // Both tasks start and end on a falling edge
    task automatic axil_write(input csr_addr_t addr, input csr_data_t data,
                              input csr_strb_t strb, output axi_resp_t resp);
        logic aw_done;
        logic w_done;
        logic aw_hs;
        logic w_hs;
        aw_done = 1'b0;
        w_done  = 1'b0;
        awaddr  = addr;
        wdata   = data;
        wstrb   = strb;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        bready  = 1'b1;
        while (!(aw_done && w_done)) begin
            aw_hs = awvalid && awready;
            w_hs  = wvalid && wready;
            @(negedge clk);
            if (aw_hs) begin
                aw_done = 1'b1;
                awvalid = 1'b0;
            end
            if (w_hs) begin
                w_done = 1'b1;
                wvalid = 1'b0;
            end
        end
        while (!bvalid) @(negedge clk);
        resp = bresp;
        @(negedge clk);
        bready = 1'b0;
    endtask

    task automatic axil_read(input csr_addr_t addr, output csr_data_t data,
                             output axi_resp_t resp);
        araddr  = addr;
        arvalid = 1'b1;
        while (!arready) @(negedge clk);
        @(negedge clk);
        arvalid = 1'b0;
        rready  = 1'b1;
        while (!rvalid) @(negedge clk);
        data = rdata;
        resp = rresp;
        @(negedge clk);
        rready = 1'b0;
    endtask

    task automatic write_ok(input string name, input csr_addr_t addr, input csr_data_t data);
        axi_resp_t resp;
        axil_write(addr, data, '1, resp);
        check_resp(name, RESP_OKAY, resp);
    endtask

    task automatic read_expect(input string name, input csr_addr_t addr, input csr_data_t exp);
        csr_data_t data;
        axi_resp_t resp;
        axil_read(addr, data, resp);
        check_data(name, exp, data);
        check_resp(name, RESP_OKAY, resp);
    endtask

    task automatic pulse_trigger(input trig_t pattern);
        dut_trig = pattern;
        @(negedge clk);
        dut_trig = '0;
    endtask

    task automatic test_reset_state();
        // Idle bus after reset
        check_bit("reset_state awready", 1'b1, awready);
        check_bit("reset_state wready", 1'b1, wready);
        check_bit("reset_state arready", 1'b1, arready);
        check_bit("reset_state bvalid", 1'b0, bvalid);
        check_bit("reset_state rvalid", 1'b0, rvalid);
        read_expect("reset_state", ADDR_EMU_STAT, 32'h0000_0003);
        read_expect("reset_state", ADDR_TRIG_STAT, '0);
        read_expect("reset_state", ADDR_CYCLE_LO, '0);
        read_expect("reset_state", ADDR_CYCLE_HI, '0);
        read_expect("reset_state", ADDR_STEP, '0);
        check_bit("reset_state halt", 1'b1, dut_halt);
        check_bit("reset_state dut_reset", 1'b1, dut_reset);
    endtask

    task automatic test_csr_access();
        csr_data_t lo;
        csr_data_t hi;
        csr_data_t step;
        axi_resp_t resp;
        lo   = $urandom;
        hi   = $urandom;
        step = $urandom;
        write_ok("csr_access", ADDR_CYCLE_LO, lo);
        write_ok("csr_access", ADDR_CYCLE_HI, hi);
        write_ok("csr_access", ADDR_STEP, step);
        read_expect("csr_access", ADDR_CYCLE_LO, lo);
        read_expect("csr_access", ADDR_CYCLE_HI, hi);
        read_expect("csr_access", ADDR_STEP, step);
        // Partial strobe must be refused and leave STEP alone
        axil_write(ADDR_STEP, ~step, 4'b0111, resp);
        check_resp("csr_access partial strobe", RESP_SLVERR, resp);
        read_expect("csr_access partial strobe", ADDR_STEP, step);
        read_expect("csr_access unmapped", 12'h0FC, '0);
    endtask

    task automatic test_step_run();
        cycle_t      start;
        cycle_t      expect_cycle;
        int unsigned n;
        start        = {32'($urandom), 32'($urandom)};
        n            = 5 + ($urandom % 36);
        expect_cycle = start + cycle_t'(n);
        write_ok("step_run", ADDR_CYCLE_LO, start[31:0]);
        write_ok("step_run", ADDR_CYCLE_HI, start[63:32]);
        write_ok("step_run", ADDR_STEP, csr_data_t'(n));
        low_cycles = 0;
        write_ok("step_run", ADDR_EMU_STAT, '0);
        while (!dut_halt) @(negedge clk);
        check_data("step_run run length", csr_data_t'(n), csr_data_t'(low_cycles));
        read_expect("step_run cycle lo", ADDR_CYCLE_LO, expect_cycle[31:0]);
        read_expect("step_run cycle hi", ADDR_CYCLE_HI, expect_cycle[63:32]);
        read_expect("step_run step", ADDR_STEP, '0);
        read_expect("step_run status", ADDR_EMU_STAT, 32'h8000_0001);
    endtask

    task automatic test_dut_trigger();
        trig_t pattern;
        do begin
            pattern = $urandom;
        end while (pattern == '0);
        write_ok("dut_trigger", ADDR_STEP, '0);
        write_ok("dut_trigger", ADDR_EMU_STAT, '0);
        repeat (3) @(negedge clk);
        check_bit("dut_trigger running", 1'b0, dut_halt);
        pulse_trigger(pattern);
        check_bit("dut_trigger halt", 1'b1, dut_halt);
        read_expect("dut_trigger trig_stat", ADDR_TRIG_STAT, pattern);
        read_expect("dut_trigger status", ADDR_EMU_STAT, 32'h0000_0001);
    endtask

    task automatic test_halted_load_guard();
        csr_data_t written;
        csr_data_t data;
        axi_resp_t resp;
        // Count starts from zero, so the low word ends equal to the cycles run
        written = $urandom | 32'h8000_0000;
        write_ok("load_guard", ADDR_CYCLE_LO, '0);
        write_ok("load_guard", ADDR_CYCLE_HI, '0);
        low_cycles = 0;
        write_ok("load_guard", ADDR_EMU_STAT, 32'h0000_0002);
        check_bit("load_guard dut_reset", 1'b1, dut_reset);
        check_bit("load_guard running", 1'b0, dut_halt);
        write_ok("load_guard", ADDR_CYCLE_LO, written);
        pulse_trigger(trig_t'(32'h0000_0100));
        check_bit("load_guard halt", 1'b1, dut_halt);
        axil_read(ADDR_CYCLE_LO, data, resp);
        check_resp("load_guard", RESP_OKAY, resp);
        check_data("load_guard cycle lo", csr_data_t'(low_cycles), data);
        read_expect("load_guard status", ADDR_EMU_STAT, 32'h0000_0003);
        write_ok("load_guard", ADDR_EMU_STAT, 32'h0000_0001);
        check_bit("load_guard dut_reset release", 1'b0, dut_reset);
    endtask

    initial begin
        sim_cycles = 0;
        while (sim_cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            sim_cycles++;
        end
        $display("Timeout: no result after %0d cycles", sim_cycles);
        $display("Done: errors found");
        $finish;
    end

    initial begin
        errors     = 0;
        low_cycles = 0;
        void'($urandom(32'he7b811c7));
        rst        = 1'b1;
        awvalid    = 1'b0;
        awaddr     = '0;
        wvalid     = 1'b0;
        wdata      = '0;
        wstrb      = '1;
        bready     = 1'b0;
        arvalid    = 1'b0;
        araddr     = '0;
        rready     = 1'b0;
        dut_trig   = '0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        test_reset_state();
        test_csr_access();
        test_step_run();
        test_dut_trigger();
        test_halted_load_guard();
        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// ==== compile.f ====
hw/emu_pkg.sv
hw/axil_csr_write.sv
hw/axil_csr_read.sv
hw/emu_run_ctrl.sv
hw/step_counter.sv
hw/cycle_counter.sv
hw/emu_ctrl_top.sv
tests/tb_emu_ctrl.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing -f compile.f --top-module tb_emu_ctrl -o tb_emu_ctrl

./obj_dir/tb_emu_ctrl | tee sim.log

if grep -qx "Done: no errors" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi
